//--- l1_cache_defines.svh
// l1 data cache geometry
// capacity, line size and the derived address field widths
`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

// data word and byte address width
`define L1_WORD_BITS 32

// capacity in bytes
`define L1_CACHE_BYTES 256

// words per line, power of two
`define L1_BLOCK_WORDS 2

// number of lines, direct mapped so one frame per set
`define L1_N_SETS (`L1_CACHE_BYTES / 4 / `L1_BLOCK_WORDS)

// index widths, never below one bit
`define L1_SET_BITS ((`L1_N_SETS > 1) ? $clog2(`L1_N_SETS) : 1)
`define L1_BLOCK_BITS ((`L1_BLOCK_WORDS > 1) ? $clog2(`L1_BLOCK_WORDS) : 1)

// what is left of the address above set, word and byte bits
`define L1_TAG_BITS (`L1_WORD_BITS - `L1_SET_BITS - `L1_BLOCK_BITS - 2)

`endif

//--- l1_cache_pkg.sv
// l1 data cache shared types
// vector typedefs sized from the geometry macros, plus the controller states
`include "l1_cache_defines.svh"

package l1_cache_pkg;

    // one data word, also used for byte addresses
    typedef logic [`L1_WORD_BITS-1:0] word_t;

    // one enable per byte of a word
    typedef logic [3:0] byte_en_t;

    // address fields
    typedef logic [`L1_TAG_BITS-1:0] tag_t;
    typedef logic [`L1_SET_BITS-1:0] set_idx_t;
    typedef logic [`L1_BLOCK_BITS-1:0] word_idx_t;

    // a whole line, word 0 in the low bits
    typedef word_t [`L1_BLOCK_WORDS-1:0] block_t;

    // controller states
    typedef enum logic [2:0] {
        SWEEP,
        LOOKUP,
        WRITEBACK,
        FILL,
        FLUSH,
        FLUSH_WB
    } cache_state_t;

endpackage

//--- frame_port_if.sv
// frame array port
// controller selects a set, reads it back combinationally, writes at the edge
`include "l1_cache_defines.svh"

interface frame_port_if;

    // selected set, shared by read and write
    l1_cache_pkg::set_idx_t set;

    // write side
    logic wr_en;
    logic wr_valid;
    logic wr_dirty;
    l1_cache_pkg::tag_t wr_tag;
    l1_cache_pkg::block_t wr_block;
    // one bit per byte over the line
    logic [`L1_BLOCK_WORDS*4-1:0] wr_mask;

    // read side
    logic rd_valid;
    logic rd_dirty;
    l1_cache_pkg::tag_t rd_tag;
    l1_cache_pkg::block_t rd_block;

    modport ctrl (
        output set, wr_en, wr_valid, wr_dirty, wr_tag, wr_block, wr_mask,
        input  rd_valid, rd_dirty, rd_tag, rd_block
    );

    modport store (
        input  set, wr_en, wr_valid, wr_dirty, wr_tag, wr_block, wr_mask,
        output rd_valid, rd_dirty, rd_tag, rd_block
    );

endinterface

//--- block_xfer_if.sv
// block transfer request port
// controller asks for one line read or write, sequencer answers with done

interface block_xfer_if;

    // one-cycle request pulse, only while idle
    logic start;
    // 1 for write-back, 0 for fill
    logic write;
    // line aligned
    l1_cache_pkg::word_t base_addr;
    // line to write, sampled with start
    l1_cache_pkg::block_t wblock;

    // fill result, valid with done
    l1_cache_pkg::block_t fill_block;
    // one-cycle pulse after the last word
    logic done;

    modport ctrl (
        output start, write, base_addr, wblock,
        input  fill_block, done
    );

    modport seq (
        input  start, write, base_addr, wblock,
        output fill_block, done
    );

endinterface

//--- cache_store.sv
// cache frame array
// per-set valid, dirty, tag and line data
// combinational read of the selected set, byte-masked write at the clock edge
`include "l1_cache_defines.svh"

module cache_store (
    input logic CLK,
    input logic nRST,
    frame_port_if.store fp
);

    localparam int MASK_BITS = `L1_BLOCK_WORDS * 4;

    // frame state, cleared by the controller sweep
    logic [`L1_N_SETS-1:0] valid_q;
    logic [`L1_N_SETS-1:0] dirty_q;
    l1_cache_pkg::tag_t tag_q [`L1_N_SETS];
    l1_cache_pkg::block_t data_q [`L1_N_SETS];

    // old line with the enabled bytes replaced
    l1_cache_pkg::block_t merged;

    // read port
    assign fp.rd_valid = valid_q[fp.set];
    assign fp.rd_dirty = dirty_q[fp.set];
    assign fp.rd_tag = tag_q[fp.set];
    assign fp.rd_block = data_q[fp.set];

    // byte merge
    always_comb begin
        merged = data_q[fp.set];
        for (int b = 0; b < MASK_BITS; b++) begin
            // byte b lives in word b/4
            if (fp.wr_mask[b]) begin
                merged[b/4][(b%4)*8 +: 8] = fp.wr_block[b/4][(b%4)*8 +: 8];
            end
        end
    end

    // write port
    always_ff @(posedge CLK) begin
        if (fp.wr_en) begin
            // state bits always follow a write
            valid_q[fp.set] <= fp.wr_valid;
            dirty_q[fp.set] <= fp.wr_dirty;
            tag_q[fp.set] <= fp.wr_tag;
            // data only where the mask says so
            data_q[fp.set] <= merged;
        end
    end

    // a line never holds dirty data without being valid
    a_dirty_implies_valid: assert property (
        @(posedge CLK) disable iff (!nRST)
        fp.rd_dirty |-> fp.rd_valid
    ) else $error("dirty line found without valid bit");

endmodule

//--- block_sequencer.sv
// block sequencer
// turns one line request into word transfers on the memory port
// words go out in order, each held until mem_busy drops
`include "l1_cache_defines.svh"

module block_sequencer (
    input  logic                 CLK,
    input  logic                 nRST,
    block_xfer_if.seq            bx,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output l1_cache_pkg::word_t  mem_addr,
    output l1_cache_pkg::word_t  mem_wdata,
    input  l1_cache_pkg::word_t  mem_rdata,
    input  logic                 mem_busy
);

    // control state
    logic busy_q;
    logic write_q;
    logic done_q;
    l1_cache_pkg::word_idx_t word_q;

    // latched request and fill data
    l1_cache_pkg::word_t base_q;
    l1_cache_pkg::block_t wblock_q;
    l1_cache_pkg::block_t fill_q;

    // a word completes this cycle
    logic beat_ok;
    logic last_word;

    assign beat_ok = busy_q && !mem_busy;
    assign last_word = (word_q == l1_cache_pkg::word_idx_t'(`L1_BLOCK_WORDS - 1));

    // memory side held stable while busy
    assign mem_ren = busy_q && !write_q;
    assign mem_wen = busy_q && write_q;
    assign mem_addr = {base_q[`L1_WORD_BITS-1:`L1_BLOCK_BITS+2], word_q, 2'b00};
    assign mem_wdata = wblock_q[word_q];

    // controller side
    assign bx.done = done_q;
    assign bx.fill_block = fill_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            write_q <= 1'b0;
            done_q <= 1'b0;
            word_q <= '0;
        end else begin
            // done follows the last completed word by one cycle
            done_q <= beat_ok && last_word;
            if (bx.start) begin
                busy_q <= 1'b1;
                write_q <= bx.write;
                word_q <= '0;
            end else if (beat_ok) begin
                if (last_word) begin
                    busy_q <= 1'b0;
                end
                // wraps back to word 0 after the last one
                word_q <= word_q + 1'b1;
            end
        end
    end

    // request and data capture
    always_ff @(posedge CLK) begin
        if (bx.start) begin
            base_q <= bx.base_addr;
            wblock_q <= bx.wblock;
        end
        // read data is only valid in the completing cycle
        if (beat_ok && !write_q) begin
            fill_q[word_q] <= mem_rdata;
        end
    end

    // controller must wait for done before the next request
    a_no_start_while_busy: assert property (
        @(posedge CLK) disable iff (!nRST)
        bx.start |-> !busy_q
    ) else $error("block start while a transfer is running");

    // a stalled word keeps its direction, address and data
    a_hold_while_stalled: assert property (
        @(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=>
            $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_wdata)
    ) else $error("memory request changed while mem_busy was high");

endmodule

//--- cache_ctrl.sv
// cache controller
// hit detection, write merge, miss write-back and fill,
// reset sweep and the flush walk over all sets
`include "l1_cache_defines.svh"

module cache_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    proc_ren,
    input  logic                    proc_wen,
    input  l1_cache_pkg::word_t     proc_addr,
    input  l1_cache_pkg::word_t     proc_wdata,
    input  l1_cache_pkg::byte_en_t  proc_byte_en,
    input  logic                    flush,
    output l1_cache_pkg::word_t     proc_rdata,
    output logic                    proc_busy,
    output logic                    flush_done,
    frame_port_if.ctrl              fp,
    block_xfer_if.ctrl              bx
);

    localparam int MASK_BITS = `L1_BLOCK_WORDS * 4;

    // control state
    l1_cache_pkg::cache_state_t state;
    l1_cache_pkg::cache_state_t next_state;
    l1_cache_pkg::set_idx_t walk_set;
    l1_cache_pkg::set_idx_t next_walk_set;
    logic flush_req;
    logic next_flush_req;
    logic flush_done_d;
    logic xfer_busy;

    // request address fields
    l1_cache_pkg::tag_t addr_tag;
    l1_cache_pkg::set_idx_t addr_set;
    l1_cache_pkg::word_idx_t addr_word;

    logic req;
    logic hit;
    logic flush_pend;
    logic last_set;
    // flush walk is done with the current set
    logic set_retire;

    assign addr_tag = proc_addr[`L1_WORD_BITS-1 -: `L1_TAG_BITS];
    assign addr_set = proc_addr[`L1_BLOCK_BITS+2 +: `L1_SET_BITS];
    assign addr_word = proc_addr[2 +: `L1_BLOCK_BITS];

    assign req = proc_ren | proc_wen;
    assign hit = fp.rd_valid && (fp.rd_tag == addr_tag);
    assign flush_pend = flush | flush_req;
    assign last_set = (walk_set == l1_cache_pkg::set_idx_t'(`L1_N_SETS - 1));

    // sweep and flush walk their own counter and everything else follows the request
    assign fp.set = (state == l1_cache_pkg::SWEEP || state == l1_cache_pkg::FLUSH ||
                     state == l1_cache_pkg::FLUSH_WB) ? walk_set : addr_set;

    // processor side
    assign proc_rdata = fp.rd_block[addr_word];
    // hits only complete in LOOKUP and not while a flush waits
    assign proc_busy = !(state == l1_cache_pkg::LOOKUP && req && hit && !flush_pend);

    // one start per transfer state since the busy flag blocks a second one
    assign bx.start = (state == l1_cache_pkg::WRITEBACK || state == l1_cache_pkg::FILL ||
                       state == l1_cache_pkg::FLUSH_WB) && !xfer_busy;
    assign bx.write = (state != l1_cache_pkg::FILL);
    // victim tag for write-back and request tag for fill
    assign bx.base_addr = {(state == l1_cache_pkg::FILL) ? addr_tag : fp.rd_tag, fp.set,
                           l1_cache_pkg::word_idx_t'(0), 2'b00};
    assign bx.wblock = fp.rd_block;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= l1_cache_pkg::SWEEP;
            walk_set <= '0;
            flush_req <= 1'b0;
            flush_done <= 1'b0;
            xfer_busy <= 1'b0;
        end else begin
            state <= next_state;
            walk_set <= next_walk_set;
            flush_req <= next_flush_req;
            flush_done <= flush_done_d;
            if (bx.start) begin
                xfer_busy <= 1'b1;
            end else if (bx.done) begin
                xfer_busy <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        next_walk_set = walk_set;
        // flush pulse held until LOOKUP takes it
        next_flush_req = flush_pend;
        flush_done_d = 1'b0;
        set_retire = 1'b0;
        fp.wr_en = 1'b0;
        fp.wr_valid = 1'b0;
        fp.wr_dirty = 1'b0;
        fp.wr_tag = addr_tag;
        fp.wr_block = '0;
        fp.wr_mask = '0;

        case (state)
            l1_cache_pkg::SWEEP: begin
                // zero one whole frame per cycle
                fp.wr_en = 1'b1;
                fp.wr_tag = '0;
                fp.wr_mask = '1;
                next_walk_set = walk_set + 1'b1;
                if (last_set) begin
                    next_walk_set = '0;
                    next_state = l1_cache_pkg::LOOKUP;
                end
            end
            l1_cache_pkg::LOOKUP: begin
                if (flush_pend) begin
                    next_flush_req = 1'b0;
                    next_state = l1_cache_pkg::FLUSH;
                end else if (req && hit) begin
                    if (proc_wen) begin
                        // merge enabled bytes into the addressed word
                        fp.wr_en = 1'b1;
                        fp.wr_valid = 1'b1;
                        fp.wr_dirty = 1'b1;
                        fp.wr_block = {`L1_BLOCK_WORDS{proc_wdata}};
                        fp.wr_mask = MASK_BITS'(proc_byte_en) << {addr_word, 2'b00};
                    end
                end else if (req) begin
                    // dirty victim goes out before the fill
                    if (fp.rd_valid && fp.rd_dirty) begin
                        next_state = l1_cache_pkg::WRITEBACK;
                    end else begin
                        next_state = l1_cache_pkg::FILL;
                    end
                end
            end
            l1_cache_pkg::WRITEBACK: begin
                if (bx.done) begin
                    next_state = l1_cache_pkg::FILL;
                end
            end
            l1_cache_pkg::FILL: begin
                if (bx.done) begin
                    // install the new line clean so the request hits next cycle
                    fp.wr_en = 1'b1;
                    fp.wr_valid = 1'b1;
                    fp.wr_block = bx.fill_block;
                    fp.wr_mask = '1;
                    next_state = l1_cache_pkg::LOOKUP;
                end
            end
            l1_cache_pkg::FLUSH: begin
                if (fp.rd_valid && fp.rd_dirty) begin
                    next_state = l1_cache_pkg::FLUSH_WB;
                end else begin
                    set_retire = 1'b1;
                end
            end
            l1_cache_pkg::FLUSH_WB: begin
                set_retire = bx.done;
            end
            default: begin
                next_state = l1_cache_pkg::SWEEP;
            end
        endcase

        // invalidate the walked set and move on
        if (set_retire) begin
            fp.wr_en = 1'b1;
            next_walk_set = walk_set + 1'b1;
            next_state = l1_cache_pkg::FLUSH;
            if (last_set) begin
                next_walk_set = '0;
                next_state = l1_cache_pkg::LOOKUP;
                flush_done_d = 1'b1;
            end
        end
    end

    // the processor is only released from LOOKUP with the sequencer idle
    a_busy_outside_lookup: assert property (
        @(posedge CLK) disable iff (!nRST)
        (state != l1_cache_pkg::LOOKUP || xfer_busy) |-> proc_busy
    ) else $error("proc_busy low outside LOOKUP or during a block transfer");

endmodule

//--- l1_cache.sv
// l1 data cache top level
// direct mapped write-back cache between a processor port and a word-wide memory port

module l1_cache (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    proc_ren,
    input  logic                    proc_wen,
    input  l1_cache_pkg::word_t     proc_addr,
    input  l1_cache_pkg::word_t     proc_wdata,
    input  l1_cache_pkg::byte_en_t  proc_byte_en,
    output l1_cache_pkg::word_t     proc_rdata,
    output logic                    proc_busy,
    input  logic                    flush,
    output logic                    flush_done,
    output logic                    mem_ren,
    output logic                    mem_wen,
    output l1_cache_pkg::word_t     mem_addr,
    output l1_cache_pkg::word_t     mem_wdata,
    input  l1_cache_pkg::word_t     mem_rdata,
    input  logic                    mem_busy
);

    // controller to frame array
    frame_port_if fp_if ();
    // controller to sequencer
    block_xfer_if bx_if ();

    cache_ctrl ctrl_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .flush        (flush),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .flush_done   (flush_done),
        .fp           (fp_if.ctrl),
        .bx           (bx_if.ctrl)
    );

    cache_store store_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .fp   (fp_if.store)
    );

    block_sequencer seq_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .bx        (bx_if.seq),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy)
    );

endmodule

//--- tb_mem_model.sv
// backing memory for the cache testbench
// 1 KiB of words preloaded from an address pattern, with random busy stalls

module tb_mem_model (
    input  logic        CLK,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        busy,
    output logic [31:0] rnd
);
    timeunit 1ns;
    timeprecision 100ps;

    // 256 words, byte address bits 9:2 select one
    logic [31:0] words [256];
    logic [31:0] lcg_q;
    logic stall;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every byte depends on the whole word address
    function automatic logic [31:0] fill_pattern(input int idx);
        logic [7:0] a;
        a = 8'(idx);
        return {a ^ 8'h5a, ~a, a + 8'h31, {a[3:0], a[7:4]}};
    endfunction

    initial begin
        lcg_q = 32'hdad2_bbe7;
        stall = 1'b0;
        for (int i = 0; i < 256; i++) begin
            words[i] = fill_pattern(i);
        end
    end

    assign rdata = ren ? words[addr[9:2]] : 32'h0;
    assign busy = stall;
    // shared random word, also feeds the stimulus
    assign rnd = lcg_q;

    // write lands when the beat completes
    always @(posedge CLK) begin
        if (wen && !busy) begin
            words[addr[9:2]] <= wdata;
        end
        lcg_q <= lcg_next(lcg_q);
    end

    // stall roughly three cycles in eight, changed just after the edge
    always @(posedge CLK) begin
        #1;
        stall = (lcg_q[22:20] < 3'd3);
    end

endmodule

//--- tb_l1_cache.sv
// testbench for the l1 data cache
// drives processor requests, keeps a reference image of memory and
// checks reads, evictions and the flush against it
`include "l1_cache_defines.svh"

module tb_l1_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAND_WRITES = 12;
    // processor accesses over all five tests
    localparam int N_REQUESTS = 8 + 2 + 8 + 3 + RAND_WRITES + 1;
    localparam int TIMEOUT_CYCLES = 200 * N_REQUESTS + 2000;
    localparam l1_cache_pkg::word_t FIRST_READS [8] = '{
        32'h000, 32'h004, 32'h010, 32'h0a8, 32'h1f0, 32'h204, 32'h3fc, 32'h2c8
    };

    logic CLK;
    logic nRST;
    logic proc_ren;
    logic proc_wen;
    l1_cache_pkg::word_t proc_addr;
    l1_cache_pkg::word_t proc_wdata;
    l1_cache_pkg::byte_en_t proc_byte_en;
    l1_cache_pkg::word_t proc_rdata;
    logic proc_busy;
    logic flush;
    logic flush_done;
    logic mem_ren;
    logic mem_wen;
    l1_cache_pkg::word_t mem_addr;
    l1_cache_pkg::word_t mem_wdata;
    l1_cache_pkg::word_t mem_rdata;
    logic mem_busy;
    logic [31:0] rnd;

    // expected memory contents, processor writes merged in
    l1_cache_pkg::word_t ref_mem [256];
    l1_cache_pkg::word_t write_log [$];
    int read_beats = 0;
    int flush_pulses = 0;
    int cycles = 0;
    int errors = 0;
    int tests_failed = 0;
    int test_start = 0;

    l1_cache l1_cache_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .flush        (flush),
        .flush_done   (flush_done),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy)
    );

    tb_mem_model mem_model_inst (
        .CLK   (CLK),
        .ren   (mem_ren),
        .wen   (mem_wen),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata),
        .busy  (mem_busy),
        .rnd   (rnd)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // memory beats and flush pulses, sampled mid-cycle
    always @(negedge CLK) begin
        if (mem_wen && !mem_busy) begin
            write_log.push_back(mem_addr);
        end
        if (mem_ren && !mem_busy) begin
            read_beats++;
        end
        if (flush_done) begin
            flush_pulses++;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic note_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input string name, input l1_cache_pkg::word_t got,
                              input l1_cache_pkg::word_t exp);
        assert (got === exp) else begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // reset holds the processor and the memory port quiet
    a_reset_quiet: assert property (
        @(posedge CLK) !nRST |-> proc_busy && !mem_ren && !mem_wen && !flush_done
    ) else note_error("outputs not in their reset state during reset");

    // a completing access never overlaps a memory beat
    a_mem_idle_on_hit: assert property (
        @(posedge CLK) disable iff (!nRST)
        !proc_busy |-> !(mem_ren || mem_wen)
    ) else note_error("memory port active while a processor access completed");

    a_flush_done_pulse: assert property (
        @(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done
    ) else note_error("flush_done held longer than one cycle");

    function automatic l1_cache_pkg::word_t fill_pattern(input int idx);
        logic [7:0] a;
        a = 8'(idx);
        return {a ^ 8'h5a, ~a, a + 8'h31, {a[3:0], a[7:4]}};
    endfunction

    function automatic l1_cache_pkg::word_t merge_bytes(input l1_cache_pkg::word_t old_w,
                                                        input l1_cache_pkg::word_t new_w,
                                                        input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // one request, entered just after a rising edge, held until proc_busy drops
    task automatic access(input logic wr, input l1_cache_pkg::word_t addr,
                          input l1_cache_pkg::word_t wdata, input l1_cache_pkg::byte_en_t be,
                          output l1_cache_pkg::word_t rdata, output int waits);
        proc_ren = !wr;
        proc_wen = wr;
        proc_addr = addr;
        proc_wdata = wdata;
        proc_byte_en = be;
        waits = 0;
        @(negedge CLK);
        while (proc_busy) begin
            waits++;
            @(negedge CLK);
        end
        rdata = proc_rdata;
        @(posedge CLK);
        #1;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic write_word(input l1_cache_pkg::word_t addr, input l1_cache_pkg::word_t data,
                              input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t rd;
        int waits;
        access(1'b1, addr, data, be, rd, waits);
        ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], data, be);
    endtask

    task automatic read_check(input l1_cache_pkg::word_t addr);
        l1_cache_pkg::word_t rd;
        int waits;
        access(1'b0, addr, '0, 4'hf, rd, waits);
        check_word($sformatf("proc_rdata @%h", addr), rd, ref_mem[addr[9:2]]);
    endtask

    task automatic end_test(input string name);
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d check(s) failed", name, errors - test_start);
            tests_failed++;
        end
        test_start = errors;
    endtask

    initial begin
        l1_cache_pkg::word_t rd;
        l1_cache_pkg::word_t addr;
        int waits;
        int beats_before;

        nRST = 1'b0;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        proc_byte_en = '0;
        flush = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_pattern(i);
        end
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // first request also waits out the sweep
        for (int i = 0; i < 8; i++) begin
            access(1'b0, FIRST_READS[i], '0, 4'hf, rd, waits);
            if (i == 0) begin
                assert (waits >= `L1_N_SETS)
                    else note_error("processor released before the reset sweep ended");
            end
            check_word("proc_rdata", rd, ref_mem[FIRST_READS[i][9:2]]);
        end
        end_test("reset sweep and first reads");

        read_check(32'h2c8);
        beats_before = read_beats;
        access(1'b0, 32'h2c8, '0, 4'hf, rd, waits);
        assert (waits == 0) else note_error("repeated read did not complete in its request cycle");
        assert (read_beats == beats_before) else note_error("repeated read went to memory");
        check_word("proc_rdata", rd, ref_mem[32'h2c8 >> 2]);
        end_test("read hit");

        // 0x0ac shares a line with 0x0a8, 0x310 evicts the clean 0x010 line
        write_word(32'h0a8, 32'h1122_3344, 4'b0001);
        read_check(32'h0a8);
        write_word(32'h0ac, 32'ha5b6_c7d8, 4'b0110);
        read_check(32'h0ac);
        write_word(32'h310, 32'hdead_beef, 4'b1100);
        read_check(32'h310);
        write_word(32'h314, 32'h0bad_f00d, 4'b1111);
        read_check(32'h314);
        end_test("byte enables");

        // 0x040 and 0x140 share set 8
        write_word(32'h040, 32'hcafe_0040, 4'hf);
        write_log.delete();
        write_word(32'h140, 32'hcafe_0140, 4'hf);
        assert (write_log.size() == 2) else note_error("eviction did not write exactly one line");
        if (write_log.size() == 2) begin
            check_word("mem_addr", write_log[0], 32'h040);
            check_word("mem_addr", write_log[1], 32'h044);
        end
        check_word("memory word 0x040", mem_model_inst.words[16], ref_mem[16]);
        read_check(32'h040);
        end_test("dirty eviction");

        addr = '0;
        for (int i = 0; i < RAND_WRITES; i++) begin
            addr = {22'd0, rnd[29:22], 2'b00};
            write_word(addr, {rnd[15:0], rnd[31:16]} ^ 32'h3c3c_a5a5, rnd[11:8]);
        end
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        while (flush_pulses == 0) begin
            @(posedge CLK);
        end
        // room for a stray second pulse
        repeat (8) @(posedge CLK);
        #1;
        assert (flush_pulses == 1) else note_error("flush_done did not pulse exactly once");
        for (int i = 0; i < 256; i++) begin
            check_word($sformatf("memory word %0d", i), mem_model_inst.words[i], ref_mem[i]);
        end
        // all lines invalid, so this must go to memory
        beats_before = read_beats;
        read_check(addr);
        assert (read_beats > beats_before) else note_error("read after flush did not reach memory");
        end_test("flush");

        $display("tests run 5, tests failed %0d, checks failed %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- l1_cache.f
+incdir+.
l1_cache_pkg.sv
frame_port_if.sv
block_xfer_if.sv
cache_store.sv
block_sequencer.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- Makefile
SIM      := verilator
VFLAGS   := --binary --assert -Wno-fatal
TOP      := tb_l1_cache
FILELIST := l1_cache.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep '\.sv$$' $(FILELIST)) l1_cache_defines.svh

.PHONY: all run clean

all: run

# rebuilt only when a listed source, the header or the list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
